// ==== common/alu_pkg.sv ====
package alu_pkg;

   // ----------------------------------------
   // sizes
   // ----------------------------------------
   localparam int DATA_W      = 16;
   localparam int TAG_W       = 4;
   localparam int NUM_PORTS   = 2;
   localparam int PORT_W      = 1;
   localparam int REQ_DEPTH   = 4;        // also the requester's initial credits.
   localparam int RSP_CREDITS = 2;        // response credits held per port.

   // ----------------------------------------
   // opcodes and payloads
   // ----------------------------------------
   typedef enum logic [1:0] {
      OP_ADD = 2'd0,
      OP_SUB = 2'd1,
      OP_MUL = 2'd2,
      OP_DIV = 2'd3
   } alu_op_e;

   typedef struct packed {
      alu_op_e           op;
      logic [DATA_W-1:0] a;
      logic [DATA_W-1:0] b;
      logic [TAG_W-1:0]  tag;
   } alu_req_t;

   typedef struct packed {
      logic [DATA_W-1:0] q;
      logic              ovf;
      logic [TAG_W-1:0]  tag;
   } alu_rsp_t;

endpackage

// ==== seq_alu/seq_alu.sv ====
module seq_alu
   import alu_pkg::*;
(
   input  logic     i_clk,
   input  logic     i_nrst,
   input  logic     i_start,
   input  alu_req_t i_req,
   output logic     o_busy,
   output logic     o_done,
   output alu_rsp_t o_rsp
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_MUL,
      ST_DIV_SH,
      ST_DIV_CMP
   } state_e;

   state_e                    state;
   logic [$clog2(DATA_W)-1:0] cnt;       // divide step.

   logic                      is_mul;
   logic                      is_div;
   logic                      a_neg;
   logic                      b_neg;
   logic                      a_min;
   logic                      b_min;
   logic                      b_zero;
   logic                      early_ovf;
   logic [DATA_W-1:0]         a_mag;
   logic [DATA_W-1:0]         b_mag;
   logic [DATA_W:0]           addsub_ext;
   logic                      neg;

   logic [DATA_W:0]           acc;       // product magnitude so far.
   logic [DATA_W:0]           mcand;
   logic [DATA_W-1:0]         mplr;
   logic [DATA_W:0]           mcand_nx;
   logic [DATA_W:0]           prod_mag;
   logic [DATA_W:0]           limit;
   logic                      mul_last;
   logic                      mul_ovf;
   logic                      mul_stop;

   logic [DATA_W-1:0]         rem;
   logic [DATA_W-1:0]         dvnd;
   logic [DATA_W-1:0]         dvsr;
   logic [DATA_W-1:0]         quo;
   logic [DATA_W:0]           rem_diff;
   logic [DATA_W-1:0]         quo_nx;

   alu_rsp_t                  rsp_r;

   // ----------------------------------------
   // operand decode
   // ----------------------------------------
   assign is_mul     = (i_req.op == OP_MUL);
   assign is_div     = (i_req.op == OP_DIV);
   assign a_neg      = i_req.a[DATA_W-1];
   assign b_neg      = i_req.b[DATA_W-1];
   assign a_min      = a_neg & ~(|i_req.a[DATA_W-2:0]);
   assign b_min      = b_neg & ~(|i_req.b[DATA_W-2:0]);
   assign b_zero     = ~(|i_req.b);
   assign early_ovf  = a_min | b_min | (is_div & b_zero);
   assign a_mag      = a_neg ? -i_req.a : i_req.a;
   assign b_mag      = b_neg ? -i_req.b : i_req.b;

   // one guard bit, overflow when it disagrees with the sign.
   assign addsub_ext = (i_req.op == OP_SUB) ? {a_neg, i_req.a} - {b_neg, i_req.b}
                                            : {a_neg, i_req.a} + {b_neg, i_req.b};

   // ----------------------------------------
   // multiply step
   // ----------------------------------------
   assign limit    = neg ? {2'b01, {(DATA_W-1){1'b0}}} : {2'b00, {(DATA_W-1){1'b1}}};
   assign prod_mag = mplr[0] ? acc + mcand : acc;
   assign mcand_nx = mcand << 1;
   assign mul_last = ~(|mplr[DATA_W-1:1]);
   // remaining multiplier bits add at least the shifted multiplicand.
   assign mul_ovf  = (prod_mag > limit) | (~mul_last & (mcand_nx > limit));
   assign mul_stop = mul_ovf | mul_last;

   // ----------------------------------------
   // divide step
   // ----------------------------------------
   assign rem_diff = {1'b0, rem} - {1'b0, dvsr};
   assign quo_nx   = {quo[DATA_W-2:0], ~rem_diff[DATA_W]};

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state  <= ST_IDLE;
         cnt    <= '0;
         o_done <= 1'b0;
      end else begin
         o_done <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (i_start) begin
                  if (!(is_mul | is_div) | early_ovf) begin
                     o_done <= 1'b1;
                  end else if (is_mul) begin
                     state <= ST_MUL;
                  end else begin
                     state <= ST_DIV_CMP;    // first shift is done at start.
                     cnt   <= '0;
                  end
               end
            end
            ST_MUL: begin
               if (mul_stop) begin
                  state  <= ST_IDLE;
                  o_done <= 1'b1;
               end
            end
            ST_DIV_SH: begin
               state <= ST_DIV_CMP;
            end
            ST_DIV_CMP: begin
               if (cnt == DATA_W-1) begin
                  state  <= ST_IDLE;
                  o_done <= 1'b1;
               end else begin
                  state <= ST_DIV_SH;
                  cnt   <= cnt + 1'b1;
               end
            end
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      case (state)
         ST_IDLE: begin
            if (i_start) begin
               rsp_r.tag <= i_req.tag;
               neg       <= a_neg ^ b_neg;
               acc       <= '0;
               mcand     <= {1'b0, b_mag};
               mplr      <= a_mag;
               rem       <= {{(DATA_W-1){1'b0}}, a_mag[DATA_W-1]};
               dvnd      <= a_mag << 1;
               dvsr      <= b_mag;
               quo       <= '0;
               if (is_mul | is_div) begin
                  rsp_r.q   <= '0;
                  rsp_r.ovf <= early_ovf;
               end else begin
                  rsp_r.q   <= addsub_ext[DATA_W-1:0];
                  rsp_r.ovf <= addsub_ext[DATA_W] ^ addsub_ext[DATA_W-1];
               end
            end
         end
         ST_MUL: begin
            acc   <= prod_mag;
            mcand <= mcand_nx;
            mplr  <= mplr >> 1;
            if (mul_stop) begin
               rsp_r.ovf <= mul_ovf;
               rsp_r.q   <= neg ? -prod_mag[DATA_W-1:0] : prod_mag[DATA_W-1:0];
            end
         end
         ST_DIV_SH: begin
            rem  <= {rem[DATA_W-2:0], dvnd[DATA_W-1]};
            dvnd <= dvnd << 1;
         end
         ST_DIV_CMP: begin
            quo <= quo_nx;
            if (!rem_diff[DATA_W]) begin
               rem <= rem_diff[DATA_W-1:0];   // restore skipped on borrow.
            end
            if (cnt == DATA_W-1) begin
               rsp_r.q <= neg ? -quo_nx : quo_nx;
            end
         end
      endcase
   end

   assign o_busy = (state != ST_IDLE);
   assign o_rsp  = rsp_r;

endmodule

// ==== rtl/credit_fifo.sv ====
module credit_fifo
   import alu_pkg::*;
#(
   parameter type payload_t = alu_req_t
) (
   input  logic     i_clk,
   input  logic     i_nrst,
   input  logic     i_push,
   input  payload_t i_data,
   input  logic     i_pop,
   output logic     o_nempty,
   output payload_t o_data,
   output logic     o_credit
);

   logic [$clog2(REQ_DEPTH)-1:0] wr_ptr;
   logic [$clog2(REQ_DEPTH)-1:0] rd_ptr;
   logic [$clog2(REQ_DEPTH):0]   count;
   logic                         pop_ok;
   payload_t                     mem [REQ_DEPTH];

   assign o_nempty = (count != '0);
   assign pop_ok   = i_pop & o_nempty;
   assign o_data   = mem[rd_ptr];
   assign o_credit = pop_ok;        // one slot freed.

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (i_push) begin
            wr_ptr <= (wr_ptr == REQ_DEPTH-1) ? '0 : wr_ptr + 1'b1;
         end
         if (pop_ok) begin
            rd_ptr <= (rd_ptr == REQ_DEPTH-1) ? '0 : rd_ptr + 1'b1;
         end
         case ({i_push, pop_ok})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_push) begin
         mem[wr_ptr] <= i_data;
      end
   end

endmodule

// ==== rtl/rr_arbiter.sv ====
module rr_arbiter
   import alu_pkg::*;
(
   input  logic                 i_clk,
   input  logic                 i_nrst,
   input  logic [NUM_PORTS-1:0] i_nempty,
   input  alu_req_t             i_head0,
   input  alu_req_t             i_head1,
   input  logic [NUM_PORTS-1:0] i_may_issue,
   input  logic                 i_busy,
   output logic [NUM_PORTS-1:0] o_pop,
   output logic                 o_start,
   output alu_req_t             o_req,
   output logic [PORT_W-1:0]    o_port
);

   logic [NUM_PORTS-1:0] elig;
   logic [PORT_W-1:0]    last_grant;
   logic [PORT_W-1:0]    pick;

   assign elig    = i_nempty & i_may_issue;
   assign o_start = ~i_busy & (|elig);

   // the port not granted last time goes first.
   assign pick    = elig[~last_grant] ? ~last_grant : last_grant;
   assign o_port  = pick;
   assign o_req   = pick ? i_head1 : i_head0;

   always_comb begin
      o_pop = '0;
      if (o_start) begin
         o_pop[pick] = 1'b1;
      end
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         last_grant <= 1'b1;          // port 0 first after reset.
      end else if (o_start) begin
         last_grant <= pick;
      end
   end

endmodule

// ==== rtl/resp_return.sv ====
module resp_return
   import alu_pkg::*;
(
   input  logic                 i_clk,
   input  logic                 i_nrst,
   input  logic                 i_start,
   input  logic [PORT_W-1:0]    i_port,
   input  logic                 i_done,
   input  alu_rsp_t             i_rsp,
   input  logic [NUM_PORTS-1:0] i_rsp_credit,
   output logic [NUM_PORTS-1:0] o_may_issue,
   output logic [NUM_PORTS-1:0] o_rsp_valid,
   output alu_rsp_t             o_rsp
);

   typedef logic [$clog2(RSP_CREDITS+1)-1:0] cred_t;

   cred_t             credits [NUM_PORTS];   // unreserved response credits.
   logic [PORT_W-1:0] port_q;

   always_comb begin
      for (int p = 0; p < NUM_PORTS; p++) begin
         o_may_issue[p] = (credits[p] != '0);
      end
   end

   // ----------------------------------------
   // credit counters, reserved at issue
   // ----------------------------------------
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         for (int p = 0; p < NUM_PORTS; p++) begin
            credits[p] <= cred_t'(RSP_CREDITS);
         end
      end else begin
         for (int p = 0; p < NUM_PORTS; p++) begin
            case ({i_start && (i_port == PORT_W'(p)), i_rsp_credit[p]})
               2'b10:   credits[p] <= credits[p] - 1'b1;
               2'b01:   credits[p] <= credits[p] + 1'b1;
               default: credits[p] <= credits[p];
            endcase
         end
      end
   end

   // ----------------------------------------
   // delivery
   // ----------------------------------------
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         port_q      <= '0;
         o_rsp_valid <= '0;
      end else begin
         o_rsp_valid <= '0;
         if (i_done) begin
            o_rsp_valid[port_q] <= 1'b1;   // port of the op now finishing.
         end
         if (i_start) begin
            port_q <= i_port;
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_done) begin
         o_rsp <= i_rsp;
      end
   end

endmodule

// ==== rtl/alu_hub.sv ====
module alu_hub
   import alu_pkg::*;
(
   input  logic              i_clk,
   input  logic              i_nrst,

   input  logic              i_req_valid_0,
   input  alu_op_e           i_req_op_0,
   input  logic [DATA_W-1:0] i_req_a_0,
   input  logic [DATA_W-1:0] i_req_b_0,
   input  logic [TAG_W-1:0]  i_req_tag_0,
   output logic              o_req_credit_0,
   output logic              o_rsp_valid_0,
   output logic [DATA_W-1:0] o_rsp_q_0,
   output logic              o_rsp_ovf_0,
   output logic [TAG_W-1:0]  o_rsp_tag_0,
   input  logic              i_rsp_credit_0,

   input  logic              i_req_valid_1,
   input  alu_op_e           i_req_op_1,
   input  logic [DATA_W-1:0] i_req_a_1,
   input  logic [DATA_W-1:0] i_req_b_1,
   input  logic [TAG_W-1:0]  i_req_tag_1,
   output logic              o_req_credit_1,
   output logic              o_rsp_valid_1,
   output logic [DATA_W-1:0] o_rsp_q_1,
   output logic              o_rsp_ovf_1,
   output logic [TAG_W-1:0]  o_rsp_tag_1,
   input  logic              i_rsp_credit_1
);

   alu_req_t             req_in0;
   alu_req_t             req_in1;
   alu_req_t             head0;
   alu_req_t             head1;
   alu_req_t             alu_req;
   alu_rsp_t             alu_rsp;
   alu_rsp_t             rsp;
   logic [NUM_PORTS-1:0] nempty;
   logic [NUM_PORTS-1:0] pop;
   logic [NUM_PORTS-1:0] req_credit;
   logic [NUM_PORTS-1:0] may_issue;
   logic [NUM_PORTS-1:0] rsp_valid;
   logic                 alu_start;
   logic                 alu_busy;
   logic                 alu_done;
   logic [PORT_W-1:0]    issue_port;

   assign req_in0 = '{op: i_req_op_0, a: i_req_a_0, b: i_req_b_0, tag: i_req_tag_0};
   assign req_in1 = '{op: i_req_op_1, a: i_req_a_1, b: i_req_b_1, tag: i_req_tag_1};

   // ----------------------------------------
   // request queues
   // ----------------------------------------
   credit_fifo #(.payload_t(alu_req_t)) u_req_q0 (
      .i_clk    (i_clk),
      .i_nrst   (i_nrst),
      .i_push   (i_req_valid_0),
      .i_data   (req_in0),
      .i_pop    (pop[0]),
      .o_nempty (nempty[0]),
      .o_data   (head0),
      .o_credit (req_credit[0])
   );

   credit_fifo #(.payload_t(alu_req_t)) u_req_q1 (
      .i_clk    (i_clk),
      .i_nrst   (i_nrst),
      .i_push   (i_req_valid_1),
      .i_data   (req_in1),
      .i_pop    (pop[1]),
      .o_nempty (nempty[1]),
      .o_data   (head1),
      .o_credit (req_credit[1])
   );

   // ----------------------------------------
   // issue, execute, return
   // ----------------------------------------
   rr_arbiter u_arb (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_nempty    (nempty),
      .i_head0     (head0),
      .i_head1     (head1),
      .i_may_issue (may_issue),
      .i_busy      (alu_busy),
      .o_pop       (pop),
      .o_start     (alu_start),
      .o_req       (alu_req),
      .o_port      (issue_port)
   );

   seq_alu u_alu (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_start (alu_start),
      .i_req   (alu_req),
      .o_busy  (alu_busy),
      .o_done  (alu_done),
      .o_rsp   (alu_rsp)
   );

   resp_return u_ret (
      .i_clk        (i_clk),
      .i_nrst       (i_nrst),
      .i_start      (alu_start),
      .i_port       (issue_port),
      .i_done       (alu_done),
      .i_rsp        (alu_rsp),
      .i_rsp_credit ({i_rsp_credit_1, i_rsp_credit_0}),
      .o_may_issue  (may_issue),
      .o_rsp_valid  (rsp_valid),
      .o_rsp        (rsp)
   );

   // result fields are shared, each valid qualifies its own port.
   assign o_req_credit_0 = req_credit[0];
   assign o_req_credit_1 = req_credit[1];
   assign o_rsp_valid_0  = rsp_valid[0];
   assign o_rsp_valid_1  = rsp_valid[1];
   assign o_rsp_q_0      = rsp.q;
   assign o_rsp_q_1      = rsp.q;
   assign o_rsp_ovf_0    = rsp.ovf;
   assign o_rsp_ovf_1    = rsp.ovf;
   assign o_rsp_tag_0    = rsp.tag;
   assign o_rsp_tag_1    = rsp.tag;

endmodule

// ==== dv/alu_hub_assert.sv ====
module alu_hub_assert
   import alu_pkg::*;
(
   input logic              i_clk,
   input logic              i_nrst,
   input logic              i_req_valid_0,
   input alu_op_e           i_req_op_0,
   input logic [DATA_W-1:0] i_req_a_0,
   input logic [DATA_W-1:0] i_req_b_0,
   input logic [TAG_W-1:0]  i_req_tag_0,
   input logic              o_req_credit_0,
   input logic              o_rsp_valid_0,
   input logic [DATA_W-1:0] o_rsp_q_0,
   input logic              o_rsp_ovf_0,
   input logic [TAG_W-1:0]  o_rsp_tag_0,
   input logic              i_rsp_credit_0,
   input logic              i_req_valid_1,
   input alu_op_e           i_req_op_1,
   input logic [DATA_W-1:0] i_req_a_1,
   input logic [DATA_W-1:0] i_req_b_1,
   input logic [TAG_W-1:0]  i_req_tag_1,
   input logic              o_req_credit_1,
   input logic              o_rsp_valid_1,
   input logic [DATA_W-1:0] o_rsp_q_1,
   input logic              o_rsp_ovf_1,
   input logic [TAG_W-1:0]  o_rsp_tag_1,
   input logic              i_rsp_credit_1
);

   localparam int S_MAX = 2**(DATA_W-1) - 1;
   localparam int S_MIN = -(2**(DATA_W-1));
   localparam int RING  = 2**TAG_W;

   int unsigned          err_cnt = 0;
   alu_req_t             order [NUM_PORTS][RING];   // requests in issue order.
   int                   wr [NUM_PORTS];
   int                   rd [NUM_PORTS];
   int                   pops [NUM_PORTS];
   int                   cred [NUM_PORTS];          // response credits the hub holds.
   logic [NUM_PORTS-1:0] req_valid;
   logic [NUM_PORTS-1:0] req_credit;
   logic [NUM_PORTS-1:0] rsp_valid;
   logic [NUM_PORTS-1:0] ret_credit;
   alu_req_t             req_in [NUM_PORTS];
   alu_req_t             cur [NUM_PORTS];
   logic                 chk_q [NUM_PORTS];
   logic [DATA_W-1:0]    exp_q [NUM_PORTS];
   logic                 exp_ovf [NUM_PORTS];
   logic [TAG_W-1:0]     exp_tag [NUM_PORTS];
   logic [DATA_W-1:0]    got_q [NUM_PORTS];
   logic                 got_ovf [NUM_PORTS];
   logic [TAG_W-1:0]     got_tag [NUM_PORTS];

   function automatic logic [DATA_W:0] ref_result(alu_req_t r);
      int   a;
      int   b;
      int   x;
      logic ovf;
      a = int'($signed(r.a));
      b = int'($signed(r.b));
      case (r.op)
         OP_ADD:  x = a + b;
         OP_SUB:  x = a - b;
         OP_MUL:  x = a * b;
         default: x = (b == 0) ? 0 : a / b;   // truncates toward zero.
      endcase
      ovf = (x > S_MAX) || (x < S_MIN);
      if (r.op == OP_MUL || r.op == OP_DIV) begin
         ovf = ovf || (a == S_MIN) || (b == S_MIN);
      end
      if (r.op == OP_DIV) begin
         ovf = ovf || (b == 0);
      end
      return {ovf, x[DATA_W-1:0]};
   endfunction

   assign req_valid  = {i_req_valid_1, i_req_valid_0};
   assign req_credit = {o_req_credit_1, o_req_credit_0};
   assign rsp_valid  = {o_rsp_valid_1, o_rsp_valid_0};
   assign ret_credit = {i_rsp_credit_1, i_rsp_credit_0};
   assign req_in[0]  = '{op: i_req_op_0, a: i_req_a_0, b: i_req_b_0, tag: i_req_tag_0};
   assign req_in[1]  = '{op: i_req_op_1, a: i_req_a_1, b: i_req_b_1, tag: i_req_tag_1};
   assign got_q[0]   = o_rsp_q_0;
   assign got_q[1]   = o_rsp_q_1;
   assign got_ovf[0] = o_rsp_ovf_0;
   assign got_ovf[1] = o_rsp_ovf_1;
   assign got_tag[0] = o_rsp_tag_0;
   assign got_tag[1] = o_rsp_tag_1;

   always_comb begin
      for (int p = 0; p < NUM_PORTS; p++) begin
         cur[p]     = order[p][rd[p] % RING];
         {exp_ovf[p], exp_q[p]} = ref_result(cur[p]);
         exp_tag[p] = cur[p].tag;
         chk_q[p]   = (cur[p].op inside {OP_ADD, OP_SUB}) || !exp_ovf[p];
      end
   end

   // ----------------------------------------
   // bookkeeping per port
   // ----------------------------------------
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         for (int p = 0; p < NUM_PORTS; p++) begin
            wr[p]   <= 0;
            rd[p]   <= 0;
            pops[p] <= 0;
            cred[p] <= RSP_CREDITS;
         end
      end else begin
         for (int p = 0; p < NUM_PORTS; p++) begin
            if (req_valid[p]) begin
               order[p][wr[p] % RING] <= req_in[p];
               wr[p] <= wr[p] + 1;
            end
            if (rsp_valid[p]) begin
               rd[p] <= rd[p] + 1;
            end
            if (req_credit[p]) begin
               pops[p] <= pops[p] + 1;
            end
            cred[p] <= cred[p] - int'(rsp_valid[p]) + int'(ret_credit[p]);
         end
      end
   end

   for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
      a_pending: assert property (@(posedge i_clk) disable iff (!i_nrst)
         rsp_valid[p] |-> wr[p] != rd[p])
         else begin
            $error("response on port %0d at %0t with no request outstanding", p, $time);
            err_cnt++;
         end
      a_tag: assert property (@(posedge i_clk) disable iff (!i_nrst)
         rsp_valid[p] && wr[p] != rd[p] |-> got_tag[p] == exp_tag[p])
         else begin
            $error("mismatch at %0t: o_rsp_tag_%0d got %0d expected %0d", $time, p,
                   $sampled(got_tag[p]), $sampled(exp_tag[p]));
            err_cnt++;
         end
      a_q: assert property (@(posedge i_clk) disable iff (!i_nrst)
         rsp_valid[p] && chk_q[p] |-> got_q[p] == exp_q[p])
         else begin
            $error("mismatch at %0t: o_rsp_q_%0d got %h expected %h", $time, p,
                   $sampled(got_q[p]), $sampled(exp_q[p]));
            err_cnt++;
         end
      a_ovf: assert property (@(posedge i_clk) disable iff (!i_nrst)
         rsp_valid[p] |-> got_ovf[p] == exp_ovf[p])
         else begin
            $error("mismatch at %0t: o_rsp_ovf_%0d got %0b expected %0b", $time, p,
                   $sampled(got_ovf[p]), $sampled(exp_ovf[p]));
            err_cnt++;
         end
      a_rsp_credit: assert property (@(posedge i_clk) disable iff (!i_nrst)
         rsp_valid[p] |-> cred[p] > 0)
         else begin
            $error("response on port %0d at %0t sent without a response credit", p, $time);
            err_cnt++;
         end
      a_req_credit: assert property (@(posedge i_clk) disable iff (!i_nrst)
         req_credit[p] |-> pops[p] < wr[p])
         else begin
            $error("request credit on port %0d at %0t exceeds accepted requests", p, $time);
            err_cnt++;
         end
   end

endmodule

bind alu_hub alu_hub_assert u_chk (.*);

// ==== dv/tb_alu_hub.sv ====
module tb_alu_hub
   import alu_pkg::*;
();

   localparam int SEED     = 62896;
   localparam int N_REQ    = 48;           // requests per port.
   localparam int HOLD_CYC = 200;          // port 1 keeps its credits this long.
   localparam int CYC_MAX  = N_REQ * (2*DATA_W+10) * NUM_PORTS + HOLD_CYC + 300;

   logic                 clk = 1'b0;
   logic                 nrst;
   logic                 hold;
   logic [NUM_PORTS-1:0] req_valid;
   logic [NUM_PORTS-1:0] req_credit;
   logic [NUM_PORTS-1:0] rsp_valid;
   logic [NUM_PORTS-1:0] rsp_credit;
   alu_op_e              req_op [NUM_PORTS];
   logic [DATA_W-1:0]    req_a [NUM_PORTS];
   logic [DATA_W-1:0]    req_b [NUM_PORTS];
   logic [TAG_W-1:0]     req_tag [NUM_PORTS];
   logic [DATA_W-1:0]    rsp_q [NUM_PORTS];
   logic                 rsp_ovf [NUM_PORTS];
   logic [TAG_W-1:0]     rsp_tag [NUM_PORTS];
   int                   got [NUM_PORTS];
   int                   cred_back [NUM_PORTS];
   int                   errs = 0;
   logic [31:0]          rng = 32'(SEED);

   always #5 clk = ~clk;

   alu_hub u_dut (
      .i_clk          (clk),
      .i_nrst         (nrst),
      .i_req_valid_0  (req_valid[0]),
      .i_req_op_0     (req_op[0]),
      .i_req_a_0      (req_a[0]),
      .i_req_b_0      (req_b[0]),
      .i_req_tag_0    (req_tag[0]),
      .o_req_credit_0 (req_credit[0]),
      .o_rsp_valid_0  (rsp_valid[0]),
      .o_rsp_q_0      (rsp_q[0]),
      .o_rsp_ovf_0    (rsp_ovf[0]),
      .o_rsp_tag_0    (rsp_tag[0]),
      .i_rsp_credit_0 (rsp_credit[0]),
      .i_req_valid_1  (req_valid[1]),
      .i_req_op_1     (req_op[1]),
      .i_req_a_1      (req_a[1]),
      .i_req_b_1      (req_b[1]),
      .i_req_tag_1    (req_tag[1]),
      .o_req_credit_1 (req_credit[1]),
      .o_rsp_valid_1  (rsp_valid[1]),
      .o_rsp_q_1      (rsp_q[1]),
      .o_rsp_ovf_1    (rsp_ovf[1]),
      .o_rsp_tag_1    (rsp_tag[1]),
      .i_rsp_credit_1 (rsp_credit[1])
   );

   function automatic logic [31:0] next_rand();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   // edge values come up often to reach overflow and zero divisors.
   function automatic logic [DATA_W-1:0] pick_operand(logic [31:0] r);
      case (r[18:16])
         3'd0:       return {1'b1, {(DATA_W-1){1'b0}}};
         3'd1:       return '0;
         3'd2, 3'd3: return DATA_W'($signed(r[7:0]));
         default:    return r[DATA_W-1:0];
      endcase
   endfunction

   // ----------------------------------------
   // requesters
   // ----------------------------------------
   task automatic send_reqs(input int p);
      int          n;
      logic [31:0] r;
      n = 0;
      while (n < N_REQ) begin
         @(posedge clk);
         #1;
         req_valid[p] = 1'b0;
         r = next_rand();
         if (n - cred_back[p] < REQ_DEPTH && r[3:0] != 4'd0) begin
            req_op[p]    = alu_op_e'(r[5:4]);
            req_a[p]     = pick_operand(next_rand());
            req_b[p]     = pick_operand(next_rand());
            req_tag[p]   = TAG_W'(n);
            req_valid[p] = 1'b1;
            n++;
         end
      end
      @(posedge clk);
      #1 req_valid[p] = 1'b0;
   endtask

   task automatic return_credits(input int p);
      int          returned;
      logic [31:0] r;
      returned = 0;
      while (returned < N_REQ) begin
         @(posedge clk);
         #1;
         r = next_rand();
         rsp_credit[p] = 1'b0;
         if (got[p] > returned && !(p == 1 && hold) && r[1:0] != 2'd0) begin
            rsp_credit[p] = 1'b1;
            returned++;
         end
      end
      @(posedge clk);
      #1 rsp_credit[p] = 1'b0;
   endtask

   task automatic stall_port1();
      int base;
      wait (got[1] >= 8);
      @(posedge clk);
      #1 hold = 1'b1;
      base = got[0];
      repeat (HOLD_CYC) @(posedge clk);
      if (got[0] < base + 4) begin
         $display("port 0 stalled while port 1 withheld credits: %0d responses in %0d cycles",
                  got[0] - base, HOLD_CYC);
         errs++;
      end
      #1 hold = 1'b0;
   endtask

   // counts are taken mid-cycle where outputs are settled.
   always @(negedge clk) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
         if (nrst && rsp_valid[p]) begin
            got[p]++;
         end
         if (nrst && req_credit[p]) begin
            cred_back[p]++;
         end
      end
   end

   initial begin
      repeat (CYC_MAX) @(posedge clk);
      $display("watchdog expired after %0d cycles, responses %0d and %0d of %0d",
               CYC_MAX, got[0], got[1], N_REQ);
      errs++;
      $display("errors: checker %0d, testbench %0d", u_dut.u_chk.err_cnt, errs);
      $display("** FAIL **");
      $finish;
   end

   initial begin
      nrst       = 1'b0;
      hold       = 1'b0;
      req_valid  = '0;
      rsp_credit = '0;
      for (int p = 0; p < NUM_PORTS; p++) begin
         req_op[p]    = OP_ADD;
         req_a[p]     = '0;
         req_b[p]     = '0;
         req_tag[p]   = '0;
         got[p]       = 0;
         cred_back[p] = 0;
      end
      repeat (8) @(posedge clk);
      #1 nrst = 1'b1;
      fork
         send_reqs(0);
         send_reqs(1);
         return_credits(0);
         return_credits(1);
         stall_port1();
      join
      repeat (10) @(posedge clk);
      for (int p = 0; p < NUM_PORTS; p++) begin
         if (got[p] != N_REQ) begin
            $display("port %0d received %0d responses for %0d requests", p, got[p], N_REQ);
            errs++;
         end
         if (cred_back[p] != N_REQ) begin
            $display("port %0d got %0d request credits back for %0d requests", p,
                     cred_back[p], N_REQ);
            errs++;
         end
      end
      $display("errors: checker %0d, testbench %0d", u_dut.u_chk.err_cnt, errs);
      if (errs == 0 && u_dut.u_chk.err_cnt == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// ==== build.f ====
common/alu_pkg.sv
seq_alu/seq_alu.sv
rtl/credit_fifo.sv
rtl/rr_arbiter.sv
rtl/resp_return.sv
rtl/alu_hub.sv
dv/alu_hub_assert.sv
dv/tb_alu_hub.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal -f build.f --top-module tb_alu_hub -o sim_tb
	./obj_dir/sim_tb +verilator+error+limit+1000 | tee $(LOG)
	grep -q "^\*\* PASS \*\*$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
